// ==== core_pkg.sv ====
// --------------------
// Data bus widths and word types
// Counter value type
// Core memory-mapped region and register offsets
// --------------------
`default_nettype none

package core_pkg;

    // --------------------
    // Data bus

    localparam int MEM_ADDR_W = 32;             // Byte address
    localparam int MEM_DATA_W = 32;             // One bus word
    localparam int MEM_STRB_W = MEM_DATA_W / 8; // One strobe per byte

    typedef logic [MEM_ADDR_W-1:0] mem_addr_t;  // Request address
    typedef logic [MEM_DATA_W-1:0] mem_data_t;  // Read or write word
    typedef logic [MEM_STRB_W-1:0] mem_strb_t;  // Byte enables

    // --------------------
    // Counters

    typedef logic [63:0] ctr_t;                 // mtime, cycle and friends

    // --------------------
    // Memory-mapped region

    localparam mem_addr_t MMIO_BASE_ADDR = 32'h0001_0000; // Region start
    localparam int        MMIO_OFFS_W    = 6;             // 64 bytes of offset

    typedef logic [MMIO_OFFS_W-1:0] mmio_offs_t;          // Offset in region

    // Register map, one word per offset
    localparam mmio_offs_t OFFS_MTIME_LO    = 6'h00;
    localparam mmio_offs_t OFFS_MTIME_HI    = 6'h04;
    localparam mmio_offs_t OFFS_MTIMECMP_LO = 6'h08;
    localparam mmio_offs_t OFFS_MTIMECMP_HI = 6'h0C;
    localparam mmio_offs_t OFFS_CYCLE_LO    = 6'h10;  // Read only
    localparam mmio_offs_t OFFS_CYCLE_HI    = 6'h14;  // Read only
    localparam mmio_offs_t OFFS_INSTRET_LO  = 6'h18;  // Read only
    localparam mmio_offs_t OFFS_INSTRET_HI  = 6'h1C;  // Read only

    // Compare parked at the top so no interrupt fires out of reset
    localparam ctr_t MTIMECMP_RESET = '1;

endpackage

`default_nettype wire

// ==== core_dmem_router.sv ====
// --------------------
// Data request router
// Splits pipeline loads and stores between external memory
// and the core timer block, and returns the chosen response
// --------------------
`timescale 1ns/1ps
`default_nettype none

module core_dmem_router (
    input  wire                      g_clk,            // Only clocks the checks
    input  wire                      i_rst_n,          // Sync active low

    input  wire                      i_dmem_req,       // Pipeline request
    input  wire core_pkg::mem_addr_t i_dmem_addr,      // Byte address
    input  wire                      i_dmem_wen,       // Store
    input  wire core_pkg::mem_strb_t i_dmem_strb,      // Byte enables
    input  wire core_pkg::mem_data_t i_dmem_wdata,     // Store data
    output logic                     o_dmem_gnt,       // Access done
    output logic                     o_dmem_err,       // Access failed
    output core_pkg::mem_data_t      o_dmem_rdata,     // Load data

    output logic                     o_ext_dmem_req,   // External memory side
    output core_pkg::mem_addr_t      o_ext_dmem_addr,
    output logic                     o_ext_dmem_wen,
    output core_pkg::mem_strb_t      o_ext_dmem_strb,
    output core_pkg::mem_data_t      o_ext_dmem_wdata,
    input  wire                      i_ext_dmem_gnt,
    input  wire                      i_ext_dmem_err,
    input  wire core_pkg::mem_data_t i_ext_dmem_rdata,

    output logic                     o_mmio_req,       // Timer block side
    output logic                     o_mmio_wen,
    output core_pkg::mem_strb_t      o_mmio_strb,
    output core_pkg::mmio_offs_t     o_mmio_addr,      // Offset in region
    output core_pkg::mem_data_t      o_mmio_wdata,
    input  wire                      i_mmio_gnt,
    input  wire                      i_mmio_err,
    input  wire core_pkg::mem_data_t i_mmio_rdata
);

    import core_pkg::*;

    logic in_region;                                   // Address hits core region

    // --------------------
    // Region decode

    assign in_region = (i_dmem_addr[MEM_ADDR_W-1:MMIO_OFFS_W] ==
                        MMIO_BASE_ADDR[MEM_ADDR_W-1:MMIO_OFFS_W]);

    // --------------------
    // Request steering

    assign o_ext_dmem_req   = i_dmem_req && !in_region;  // Other target held off
    assign o_ext_dmem_addr  = i_dmem_addr;               // Full address kept
    assign o_ext_dmem_wen   = i_dmem_wen;
    assign o_ext_dmem_strb  = i_dmem_strb;
    assign o_ext_dmem_wdata = i_dmem_wdata;

    assign o_mmio_req   = i_dmem_req && in_region;
    assign o_mmio_addr  = i_dmem_addr[MMIO_OFFS_W-1:0];  // Offset bits only
    assign o_mmio_wen   = i_dmem_wen;
    assign o_mmio_strb  = i_dmem_strb;
    assign o_mmio_wdata = i_dmem_wdata;

    // --------------------
    // Response select

    always_comb begin
        if (in_region) begin
            o_dmem_gnt   = i_mmio_gnt;        // Fixed latency path
            o_dmem_err   = i_mmio_err;
            o_dmem_rdata = i_mmio_rdata;
        end else begin
            o_dmem_gnt   = i_ext_dmem_gnt;    // Memory sets the latency
            o_dmem_err   = i_ext_dmem_err;
            o_dmem_rdata = i_ext_dmem_rdata;
        end
    end

    // --------------------
    // Bus checks

    // Pipeline holds its request until granted
    a_req_stable: assert property (@(posedge g_clk) disable iff (!i_rst_n)
        (i_dmem_req && !o_dmem_gnt) |=> (i_dmem_req && $stable(i_dmem_addr) &&
        $stable(i_dmem_wen) && $stable(i_dmem_strb) && $stable(i_dmem_wdata)))
        else $error("dmem request changed before grant");

    a_one_target: assert property (@(posedge g_clk) disable iff (!i_rst_n)
        !(o_ext_dmem_req && o_mmio_req))
        else $error("both targets requested");

    // Targets only answer what they were asked
    a_ext_gnt_req: assert property (@(posedge g_clk) disable iff (!i_rst_n)
        i_ext_dmem_gnt |-> o_ext_dmem_req)
        else $error("external grant without request");

    a_mmio_gnt_req: assert property (@(posedge g_clk) disable iff (!i_rst_n)
        i_mmio_gnt |-> o_mmio_req)
        else $error("timer block grant without request");

endmodule

`default_nettype wire

// ==== core_counters.sv ====
// --------------------
// Timer and counter block
// mtime, mtimecmp, cycle and instret with word access
// over the region bus, plus the timer interrupt
// --------------------
`timescale 1ns/1ps
`default_nettype none

module core_counters (
    input  wire                       g_clk,
    input  wire                       i_rst_n,        // Sync active low

    input  wire                       i_instr_ret,    // One per retired instr

    input  wire                       i_mmio_req,     // Region request
    input  wire                       i_mmio_wen,     // Write
    input  wire core_pkg::mem_strb_t  i_mmio_strb,    // Byte enables
    input  wire core_pkg::mmio_offs_t i_mmio_addr,    // Byte offset
    input  wire core_pkg::mem_data_t  i_mmio_wdata,
    output logic                      o_mmio_gnt,     // One cycle after req
    output logic                      o_mmio_err,     // Bad offset or RO write
    output core_pkg::mem_data_t       o_mmio_rdata,   // Zero on error

    output logic                      o_timer_irq     // mtime >= mtimecmp
);

    import core_pkg::*;

    ctr_t mtime_q;        // Real time
    ctr_t mtimecmp_q;     // Timer compare
    ctr_t cycle_q;        // Clock count
    ctr_t instret_q;      // Retired count
    ctr_t mtime_d;        // Incremented or written
    ctr_t mtimecmp_d;

    logic gnt_q;          // Grant stage
    logic irq_q;

    logic sel_mtime_lo;   // Offset decode
    logic sel_mtime_hi;
    logic sel_cmp_lo;
    logic sel_cmp_hi;
    logic sel_cycle_lo;
    logic sel_cycle_hi;
    logic sel_instret_lo;
    logic sel_instret_hi;
    logic map_hit;        // Any register
    logic ro_hit;         // A read-only register
    logic misaligned;
    logic acc_err;
    logic wr_ok;          // Commit a write this edge

    mem_data_t rd_word;

    // Byte-wise replace of a word
    function automatic mem_data_t strb_merge(input mem_data_t old_word,
                                             input mem_data_t new_word,
                                             input mem_strb_t strb);
        mem_data_t merged;
        merged = old_word;
        for (int b = 0; b < MEM_STRB_W; b++) begin
            if (strb[b]) begin
                merged[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return merged;
    endfunction

    // --------------------
    // Access decode

    assign sel_mtime_lo   = (i_mmio_addr == OFFS_MTIME_LO);
    assign sel_mtime_hi   = (i_mmio_addr == OFFS_MTIME_HI);
    assign sel_cmp_lo     = (i_mmio_addr == OFFS_MTIMECMP_LO);
    assign sel_cmp_hi     = (i_mmio_addr == OFFS_MTIMECMP_HI);
    assign sel_cycle_lo   = (i_mmio_addr == OFFS_CYCLE_LO);
    assign sel_cycle_hi   = (i_mmio_addr == OFFS_CYCLE_HI);
    assign sel_instret_lo = (i_mmio_addr == OFFS_INSTRET_LO);
    assign sel_instret_hi = (i_mmio_addr == OFFS_INSTRET_HI);

    assign ro_hit  = sel_cycle_lo || sel_cycle_hi || sel_instret_lo || sel_instret_hi;
    assign map_hit = sel_mtime_lo || sel_mtime_hi || sel_cmp_lo || sel_cmp_hi || ro_hit;

    assign misaligned = |i_mmio_addr[1:0];                 // Word access only
    assign acc_err    = misaligned || !map_hit || (i_mmio_wen && ro_hit);

    assign wr_ok = gnt_q && i_mmio_req && i_mmio_wen && !acc_err;

    // --------------------
    // Read data

    always_comb begin
        rd_word = '0;
        unique case (1'b1)
            sel_mtime_lo:   rd_word = mtime_q[MEM_DATA_W-1:0];
            sel_mtime_hi:   rd_word = mtime_q[MEM_DATA_W +: MEM_DATA_W];
            sel_cmp_lo:     rd_word = mtimecmp_q[MEM_DATA_W-1:0];
            sel_cmp_hi:     rd_word = mtimecmp_q[MEM_DATA_W +: MEM_DATA_W];
            sel_cycle_lo:   rd_word = cycle_q[MEM_DATA_W-1:0];
            sel_cycle_hi:   rd_word = cycle_q[MEM_DATA_W +: MEM_DATA_W];
            sel_instret_lo: rd_word = instret_q[MEM_DATA_W-1:0];
            sel_instret_hi: rd_word = instret_q[MEM_DATA_W +: MEM_DATA_W];
            default:        rd_word = '0;              // Unmapped
        endcase
    end

    assign o_mmio_gnt   = gnt_q;
    assign o_mmio_err   = acc_err;
    assign o_mmio_rdata = acc_err ? '0 : rd_word;      // Value as of grant cycle

    // --------------------
    // Next timer values

    always_comb begin
        mtime_d = mtime_q + 64'd1;                     // Free running
        if (wr_ok && sel_mtime_lo) begin
            mtime_d[MEM_DATA_W-1:0] = strb_merge(mtime_d[MEM_DATA_W-1:0],
                                                 i_mmio_wdata, i_mmio_strb);
        end
        if (wr_ok && sel_mtime_hi) begin
            mtime_d[MEM_DATA_W +: MEM_DATA_W] =
                strb_merge(mtime_d[MEM_DATA_W +: MEM_DATA_W], i_mmio_wdata, i_mmio_strb);
        end
    end

    always_comb begin
        mtimecmp_d = mtimecmp_q;                       // Holds unless written
        if (wr_ok && sel_cmp_lo) begin
            mtimecmp_d[MEM_DATA_W-1:0] = strb_merge(mtimecmp_q[MEM_DATA_W-1:0],
                                                    i_mmio_wdata, i_mmio_strb);
        end
        if (wr_ok && sel_cmp_hi) begin
            mtimecmp_d[MEM_DATA_W +: MEM_DATA_W] =
                strb_merge(mtimecmp_q[MEM_DATA_W +: MEM_DATA_W], i_mmio_wdata, i_mmio_strb);
        end
    end

    // --------------------
    // Registers

    always_ff @(posedge g_clk) begin
        if (!i_rst_n) begin
            gnt_q <= 1'b0;
        end else begin
            gnt_q <= i_mmio_req && !gnt_q;             // Idle cycle after each grant
        end
    end

    always_ff @(posedge g_clk) begin
        if (!i_rst_n) begin
            mtime_q    <= '0;
            mtimecmp_q <= MTIMECMP_RESET;
            cycle_q    <= '0;
            instret_q  <= '0;
        end else begin
            mtime_q    <= mtime_d;
            mtimecmp_q <= mtimecmp_d;
            cycle_q    <= cycle_q + 64'd1;
            instret_q  <= instret_q + ctr_t'(i_instr_ret);
        end
    end

    always_ff @(posedge g_clk) begin
        if (!i_rst_n) begin
            irq_q <= 1'b0;
        end else begin
            irq_q <= (mtime_q >= mtimecmp_q);          // One cycle behind compare
        end
    end

    assign o_timer_irq = irq_q;

    // Region accesses take two cycles each
    a_gnt_gap: assert property (@(posedge g_clk) disable iff (!i_rst_n)
        o_mmio_gnt |=> !o_mmio_gnt)
        else $error("timer block granted twice in a row");

endmodule

`default_nettype wire

// ==== core_data_port.sv ====
// --------------------
// Data-side memory path of the core
// Router plus timer and counter block
// --------------------
`timescale 1ns/1ps
`default_nettype none

module core_data_port (
    input  wire                      g_clk,
    input  wire                      i_rst_n,           // Sync active low

    input  wire                      i_dmem_req,        // From pipeline
    input  wire core_pkg::mem_addr_t i_dmem_addr,
    input  wire                      i_dmem_wen,
    input  wire core_pkg::mem_strb_t i_dmem_strb,
    input  wire core_pkg::mem_data_t i_dmem_wdata,
    input  wire                      i_instr_ret,       // Retire pulse
    output logic                     o_dmem_gnt,
    output logic                     o_dmem_err,
    output core_pkg::mem_data_t      o_dmem_rdata,

    output logic                     o_ext_dmem_req,    // To data memory
    output core_pkg::mem_addr_t      o_ext_dmem_addr,
    output logic                     o_ext_dmem_wen,
    output core_pkg::mem_strb_t      o_ext_dmem_strb,
    output core_pkg::mem_data_t      o_ext_dmem_wdata,
    input  wire                      i_ext_dmem_gnt,
    input  wire                      i_ext_dmem_err,
    input  wire core_pkg::mem_data_t i_ext_dmem_rdata,

    output logic                     o_timer_irq        // Timer level
);

    import core_pkg::*;

    // --------------------
    // Router to timer block

    logic       mmio_req;
    logic       mmio_wen;
    mem_strb_t  mmio_strb;
    mmio_offs_t mmio_addr;        // Offset only
    mem_data_t  mmio_wdata;
    logic       mmio_gnt;
    logic       mmio_err;
    mem_data_t  mmio_rdata;

    core_dmem_router core_dmem_router_inst (
        .g_clk            (g_clk),
        .i_rst_n          (i_rst_n),
        .i_dmem_req       (i_dmem_req),
        .i_dmem_addr      (i_dmem_addr),
        .i_dmem_wen       (i_dmem_wen),
        .i_dmem_strb      (i_dmem_strb),
        .i_dmem_wdata     (i_dmem_wdata),
        .o_dmem_gnt       (o_dmem_gnt),
        .o_dmem_err       (o_dmem_err),
        .o_dmem_rdata     (o_dmem_rdata),
        .o_ext_dmem_req   (o_ext_dmem_req),     // Outside the region
        .o_ext_dmem_addr  (o_ext_dmem_addr),
        .o_ext_dmem_wen   (o_ext_dmem_wen),
        .o_ext_dmem_strb  (o_ext_dmem_strb),
        .o_ext_dmem_wdata (o_ext_dmem_wdata),
        .i_ext_dmem_gnt   (i_ext_dmem_gnt),
        .i_ext_dmem_err   (i_ext_dmem_err),
        .i_ext_dmem_rdata (i_ext_dmem_rdata),
        .o_mmio_req       (mmio_req),           // Inside the region
        .o_mmio_wen       (mmio_wen),
        .o_mmio_strb      (mmio_strb),
        .o_mmio_addr      (mmio_addr),
        .o_mmio_wdata     (mmio_wdata),
        .i_mmio_gnt       (mmio_gnt),
        .i_mmio_err       (mmio_err),
        .i_mmio_rdata     (mmio_rdata)
    );

    core_counters core_counters_inst (
        .g_clk        (g_clk),
        .i_rst_n      (i_rst_n),
        .i_instr_ret  (i_instr_ret),            // Drives instret
        .i_mmio_req   (mmio_req),
        .i_mmio_wen   (mmio_wen),
        .i_mmio_strb  (mmio_strb),
        .i_mmio_addr  (mmio_addr),
        .i_mmio_wdata (mmio_wdata),
        .o_mmio_gnt   (mmio_gnt),
        .o_mmio_err   (mmio_err),
        .o_mmio_rdata (mmio_rdata),
        .o_timer_irq  (o_timer_irq)
    );

endmodule

`default_nettype wire

// ==== tb_core_data_port_tests.svh ====
// --------------------
// Directed tests for the core data port
// Bus access helpers, external routing, region access,
// region errors, counters and timer interrupt
// --------------------
`ifndef TB_CORE_DATA_PORT_TESTS_SVH
`define TB_CORE_DATA_PORT_TESTS_SVH

mem_data_t ref_mem [0:255];                      // Expected external memory
ctr_t      cmp_exp   = MTIMECMP_RESET;           // Expected mtimecmp
int        ret_count = 0;                        // Retire pulses since reset
int        gnt_cyc   = 0;                        // Edge count at last grant

task automatic check_word(input mem_data_t got, input mem_data_t exp, input string what);
    assert (got === exp) else begin
        $display("mismatch at %0t ns: %s, got %h expected %h", $time, what, got, exp);
        stop_run("value mismatch");
    end
endtask

task automatic check_bit(input logic got, input logic exp, input string what);
    assert (got === exp) else begin
        $display("mismatch at %0t ns: %s, got %b expected %b", $time, what, got, exp);
        stop_run("value mismatch");
    end
endtask

task automatic rand_word(output logic [31:0] v);
    stim_state = xorshift32(stim_state);
    v = stim_state;
endtask

// --------------------
// Bus access

// External port must mirror the request, or stay quiet for the region
task automatic check_route(input logic region, input mem_addr_t addr, input logic wen,
                           input mem_strb_t strb, input mem_data_t wdata);
    if (region) begin
        check_bit(ext_req, 1'b0, "external req during region access");
    end else begin
        check_bit(ext_req, 1'b1, "external req");
        check_word(ext_addr, addr, "external addr");
        check_bit(ext_wen, wen, "external wen");
        check_word({28'h0, ext_strb}, {28'h0, strb}, "external strb");
        check_word(ext_wdata, wdata, "external wdata");
    end
endtask

task automatic dmem_access(input logic region, input mem_addr_t addr, input logic wen,
                           input mem_strb_t strb, input mem_data_t wdata,
                           output mem_data_t rdata, output logic err, output int lat);
    lat = 0;
    @(posedge g_clk);
    dmem_req   <= 1'b1;
    dmem_addr  <= addr;
    dmem_wen   <= wen;
    dmem_strb  <= strb;
    dmem_wdata <= wdata;
    @(negedge g_clk);
    while (!dmem_gnt && lat < GNT_LIMIT) begin
        check_route(region, addr, wen, strb, wdata);
        lat++;
        @(negedge g_clk);
    end
    if (!dmem_gnt) begin
        $display("no grant for address %h after %0d cycles", addr, lat);
        stop_run("grant timeout");
    end else begin
        check_route(region, addr, wen, strb, wdata);
        rdata   = dmem_rdata;                    // Valid in grant cycle only
        err     = dmem_err;
        gnt_cyc = cyc;
        @(posedge g_clk);
        dmem_req <= 1'b0;
    end
endtask

task automatic region_read(input mmio_offs_t offs, output mem_data_t rdata,
                           output logic err);
    int lat;
    dmem_access(1'b1, MMIO_BASE_ADDR | mem_addr_t'(offs), 1'b0, 4'hF, '0, rdata, err, lat);
    check_word(mem_data_t'(lat), 32'd1, "region read grant latency");
endtask

task automatic region_write(input mmio_offs_t offs, input mem_strb_t strb,
                            input mem_data_t wdata, output logic err);
    mem_data_t rdata;
    int lat;
    dmem_access(1'b1, MMIO_BASE_ADDR | mem_addr_t'(offs), 1'b1, strb, wdata, rdata, err, lat);
    check_word(mem_data_t'(lat), 32'd1, "region write grant latency");
endtask

// --------------------
// Tests

task automatic test_ext_routing();
    mem_addr_t addrs [EXT_OPS/2];
    mem_data_t r;
    mem_data_t wdata;
    mem_data_t rdata;
    logic      err;
    int        lat;
    for (int i = 0; i < 256; i++) begin
        ref_mem[i] = fill_word(8'(i));
    end
    for (int n = 0; n < EXT_OPS/2; n++) begin
        rand_word(r);
        addrs[n] = {r[31] & r[30], 21'h0, r[9:2], 2'b00};  // Bit 16 clear, never region
        rand_word(wdata);
        dmem_access(1'b0, addrs[n], 1'b1, r[13:10], wdata, rdata, err, lat);
        check_bit(err, addrs[n][31], "external write err");
        check_bit(lat >= 1 && lat <= 4, 1'b1, "external write latency in range");
        if (!addrs[n][31]) begin
            ref_mem[addrs[n][9:2]] = byte_replace(ref_mem[addrs[n][9:2]], wdata, r[13:10]);
        end
    end
    for (int n = 0; n < EXT_OPS/2; n++) begin
        dmem_access(1'b0, addrs[n], 1'b0, 4'hF, '0, rdata, err, lat);
        check_bit(err, addrs[n][31], "external read err");
        check_bit(lat >= 1 && lat <= 4, 1'b1, "external read latency in range");
        if (!addrs[n][31]) begin
            check_word(rdata, ref_mem[addrs[n][9:2]], "external read data");
        end
    end
endtask

task automatic test_region_access();
    mem_data_t rdata;
    mem_data_t wdata;
    logic      err;
    region_read(OFFS_MTIMECMP_LO, rdata, err);
    check_bit(err, 1'b0, "mtimecmp lo read err");
    check_word(rdata, cmp_exp[31:0], "mtimecmp lo after reset");
    region_read(OFFS_MTIMECMP_HI, rdata, err);
    check_word(rdata, cmp_exp[63:32], "mtimecmp hi after reset");
    rand_word(wdata);
    region_write(OFFS_MTIMECMP_LO, 4'b0101, wdata, err);
    check_bit(err, 1'b0, "mtimecmp lo write err");
    cmp_exp[31:0] = byte_replace(cmp_exp[31:0], wdata, 4'b0101);
    region_read(OFFS_MTIMECMP_LO, rdata, err);
    check_word(rdata, cmp_exp[31:0], "mtimecmp lo partial write");
    rand_word(wdata);
    region_write(OFFS_MTIMECMP_HI, 4'b1000, wdata, err);  // Top byte only, irq stays off
    check_bit(err, 1'b0, "mtimecmp hi write err");
    cmp_exp[63:32] = byte_replace(cmp_exp[63:32], wdata, 4'b1000);
    region_read(OFFS_MTIMECMP_HI, rdata, err);
    check_word(rdata, cmp_exp[63:32], "mtimecmp hi partial write");
    region_read(OFFS_MTIMECMP_LO, rdata, err);
    check_word(rdata, cmp_exp[31:0], "mtimecmp lo kept");
endtask

task automatic test_region_errors();
    mem_data_t rdata;
    mem_data_t first;
    logic      err;
    int        first_cyc;
    region_read(6'h20, rdata, err);              // Past the register map
    check_bit(err, 1'b1, "unmapped read err");
    check_word(rdata, 32'h0, "unmapped read data");
    region_write(6'h24, 4'hF, 32'hDEAD_BEEF, err);
    check_bit(err, 1'b1, "unmapped write err");
    region_write(6'h09, 4'hF, 32'h1234_5678, err);  // Inside mtimecmp lo
    check_bit(err, 1'b1, "misaligned write err");
    region_read(6'h0A, rdata, err);
    check_bit(err, 1'b1, "misaligned read err");
    check_word(rdata, 32'h0, "misaligned read data");
    region_read(OFFS_MTIMECMP_LO, rdata, err);
    check_word(rdata, cmp_exp[31:0], "mtimecmp lo after misaligned write");
    region_read(OFFS_CYCLE_LO, first, err);
    first_cyc = gnt_cyc;
    region_write(OFFS_CYCLE_LO, 4'hF, 32'h0, err);
    check_bit(err, 1'b1, "cycle lo write err");
    region_read(OFFS_CYCLE_LO, rdata, err);
    check_word(rdata - first, mem_data_t'(gnt_cyc - first_cyc), "cycle after write");
    region_write(OFFS_INSTRET_HI, 4'hF, 32'hFFFF_FFFF, err);
    check_bit(err, 1'b1, "instret hi write err");
    region_read(OFFS_INSTRET_HI, rdata, err);
    check_word(rdata, 32'h0, "instret hi after write");
endtask

task automatic test_counters();
    mem_data_t r;
    mem_data_t rdata;
    mem_data_t first;
    logic      err;
    int        first_cyc;
    int        gap;
    for (int n = 0; n < RET_CYC; n++) begin
        rand_word(r);
        @(posedge g_clk);
        instr_ret <= r[0];
        ret_count += int'(r[0]);
    end
    @(posedge g_clk);
    instr_ret <= 1'b0;
    region_read(OFFS_INSTRET_LO, rdata, err);
    check_bit(err, 1'b0, "instret lo read err");
    check_word(rdata, mem_data_t'(ret_count), "instret lo");
    region_read(OFFS_INSTRET_HI, rdata, err);
    check_word(rdata, 32'h0, "instret hi");
    region_read(OFFS_CYCLE_LO, first, err);
    first_cyc = gnt_cyc;
    rand_word(r);
    gap = int'(r[3:0]) + 8;                      // Idle stretch between reads
    repeat (gap) @(posedge g_clk);
    region_read(OFFS_CYCLE_LO, rdata, err);
    check_word(rdata - first, mem_data_t'(gnt_cyc - first_cyc), "cycle delta");
endtask

task automatic test_timer_irq();
    mem_data_t mt0;
    logic      err;
    int        clr_cyc;
    int        mt;
    int        waited;
    check_bit(timer_irq, 1'b0, "timer irq before compare setup");
    region_write(OFFS_MTIMECMP_HI, 4'hF, 32'h0, err);
    region_write(OFFS_MTIME_LO, 4'hF, 32'h0, err);
    clr_cyc = gnt_cyc;                           // mtime lo is zero one edge later
    region_write(OFFS_MTIME_HI, 4'hF, 32'h0, err);
    region_write(OFFS_MTIMECMP_LO, 4'hF, 32'd100, err);
    check_bit(err, 1'b0, "mtimecmp lo write err");
    region_read(OFFS_MTIME_LO, mt0, err);
    check_word(mt0, mem_data_t'(gnt_cyc - clr_cyc - 1), "mtime lo after clear");
    waited = 0;
    do begin
        @(negedge g_clk);
        mt = cyc - clr_cyc - 1;                  // mtime tracks edge count
        if (mt < 100) begin
            check_bit(timer_irq, 1'b0, "timer irq before mtime reaches mtimecmp");
        end
        waited++;
    end while (mt < 102 && waited < IRQ_WAIT);
    check_bit(timer_irq, 1'b1, "timer irq two cycles after mtime reaches mtimecmp");
    region_write(OFFS_MTIMECMP_HI, 4'hF, 32'hFFFF_FFFF, err);
    repeat (2) @(negedge g_clk);
    check_bit(timer_irq, 1'b0, "timer irq after raising mtimecmp");
endtask

`endif

// ==== tb_core_data_port.sv ====
// --------------------
// Testbench top for the core data port
// Clock, reset, DUT, external data memory model
// xorshift source and watchdog
// --------------------
`timescale 1ns/1ps
`default_nettype none

module tb_core_data_port;

    import core_pkg::*;

    localparam logic [31:0] SEED  = 32'd53047;   // Shared start value
    localparam int RESET_CYC      = 3;
    localparam int GNT_LIMIT      = 16;          // Cycles before a grant timeout
    localparam int ACC_CYC        = 7;           // Worst access incl. idle cycle
    localparam int EXT_OPS        = 32;          // Writes plus reads
    localparam int RET_CYC        = 40;          // Retire pulse window
    localparam int IRQ_WAIT       = 120;         // mtime climb to compare
    localparam int TEST_CYC       = EXT_OPS * ACC_CYC + 7 * ACC_CYC + 10 * ACC_CYC
                                    + (RET_CYC + 24 + 3 * ACC_CYC)
                                    + (IRQ_WAIT + 7 * ACC_CYC);
    localparam int WATCHDOG_CYC   = 2 * (RESET_CYC + TEST_CYC);

    logic      g_clk      = 1'b0;
    logic      rst_n      = 1'b0;
    logic      dmem_req   = 1'b0;                // Pipeline side
    mem_addr_t dmem_addr  = '0;
    logic      dmem_wen   = 1'b0;
    mem_strb_t dmem_strb  = '0;
    mem_data_t dmem_wdata = '0;
    logic      instr_ret  = 1'b0;
    logic      dmem_gnt;
    logic      dmem_err;
    mem_data_t dmem_rdata;

    logic      ext_req;                          // External memory side
    mem_addr_t ext_addr;
    logic      ext_wen;
    mem_strb_t ext_strb;
    mem_data_t ext_wdata;
    logic      ext_gnt    = 1'b0;
    logic      ext_err    = 1'b0;
    mem_data_t ext_rdata  = '0;
    logic      timer_irq;

    mem_data_t   ext_mem [0:255];                // Model storage
    logic [1:0]  ext_delay   = 2'd0;             // Wait for current request
    logic [1:0]  ext_wait    = 2'd0;
    logic [31:0] model_state = SEED;             // Model random stream
    logic [31:0] stim_state  = SEED;             // Test random stream
    int          cyc         = 0;                // Rising edges so far

    always #10 g_clk = ~g_clk;                   // 20 ns period

    always @(posedge g_clk) begin
        cyc <= cyc + 1;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Every byte of a word carries its index
    function automatic mem_data_t fill_word(input logic [7:0] idx);
        return {idx ^ 8'h5A, ~idx, idx + 8'h3C, idx};
    endfunction

    function automatic mem_data_t byte_replace(input mem_data_t old_word,
                                               input mem_data_t new_word,
                                               input mem_strb_t strb);
        mem_data_t mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    task automatic stop_run(input string why);
        $display("test failed");
        $fatal(1, "%s", why);
    endtask

    core_data_port core_data_port_inst (
        .g_clk            (g_clk),
        .i_rst_n          (rst_n),
        .i_dmem_req       (dmem_req),
        .i_dmem_addr      (dmem_addr),
        .i_dmem_wen       (dmem_wen),
        .i_dmem_strb      (dmem_strb),
        .i_dmem_wdata     (dmem_wdata),
        .i_instr_ret      (instr_ret),
        .o_dmem_gnt       (dmem_gnt),
        .o_dmem_err       (dmem_err),
        .o_dmem_rdata     (dmem_rdata),
        .o_ext_dmem_req   (ext_req),
        .o_ext_dmem_addr  (ext_addr),
        .o_ext_dmem_wen   (ext_wen),
        .o_ext_dmem_strb  (ext_strb),
        .o_ext_dmem_wdata (ext_wdata),
        .i_ext_dmem_gnt   (ext_gnt),
        .i_ext_dmem_err   (ext_err),
        .i_ext_dmem_rdata (ext_rdata),
        .o_timer_irq      (timer_irq)
    );

    // --------------------
    // External memory model

    always @(posedge g_clk) begin
        if (!rst_n) begin
            ext_gnt  <= 1'b0;
            ext_err  <= 1'b0;
            ext_wait <= 2'd0;
        end else if (ext_gnt) begin
            ext_gnt <= 1'b0;                     // Single cycle grant
            ext_err <= 1'b0;
        end else if (ext_req) begin
            if (ext_wait == ext_delay) begin
                ext_gnt   <= 1'b1;
                ext_err   <= ext_addr[31];       // Upper half faults
                ext_rdata <= ext_mem[ext_addr[9:2]];
                if (ext_wen && !ext_addr[31]) begin
                    ext_mem[ext_addr[9:2]] <= byte_replace(ext_mem[ext_addr[9:2]],
                                                           ext_wdata, ext_strb);
                end
                ext_wait    <= 2'd0;
                ext_delay   <= model_state[1:0]; // Next request waits 0 to 3
                model_state <= xorshift32(model_state);
            end else begin
                ext_wait <= ext_wait + 2'd1;
            end
        end
    end

    `include "tb_core_data_port_tests.svh"

    // --------------------
    // Test sequence

    initial begin
        for (int i = 0; i < 256; i++) begin
            ext_mem[i] = fill_word(8'(i));
        end
        repeat (RESET_CYC) @(posedge g_clk);
        rst_n <= 1'b1;
        @(negedge g_clk);
        check_bit(timer_irq, 1'b0, "timer irq after reset");
        check_bit(dmem_gnt, 1'b0, "dmem gnt after reset");
        check_bit(ext_req, 1'b0, "external req after reset");
        test_ext_routing();
        test_region_access();
        test_region_errors();
        test_counters();
        test_timer_irq();
        $display("test passed");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYC) @(posedge g_clk);
        $display("watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYC);
        stop_run("watchdog expired");
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+.
core_pkg.sv
core_dmem_router.sv
core_counters.sv
core_data_port.sv
tb_core_data_port.sv

// ==== Makefile ====
# Verilator simulation of the core data port

TOP := tb_core_data_port

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f sources.f -Mdir obj_dir -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir
